//--- bench/smc_mac_assert.sv
//----------------------------------------
// access protocol assertions
// bound into the multiple access top level
//----------------------------------------

`timescale 1ns/10ps

module smc_mac_assert (
  input logic                  sys_clk,
  input logic                  n_sys_reset,
  input logic                  valid_access,
  input smc_mac_pkg::size_t    xfer_size,
  input smc_mac_pkg::mem_rsp_t mem_rsp,
  input logic                  mac_done,
  input logic [31:0]           smc_data
);

  strobe_not_on_done: assert property (@(posedge sys_clk) disable iff (!n_sys_reset)
    !(valid_access && mem_rsp.done))
    else $error("valid_access and mem_rsp.done in the same cycle");

  // wide transfer on the byte bus needs more than one access
  wide_not_done: assert property (@(posedge sys_clk) disable iff (!n_sys_reset)
    valid_access && xfer_size != smc_mac_pkg::XSIZ_8 |=> !mac_done)
    else $error("mac_done high right after a wide transfer start");

  upper_lanes_zero: assert property (@(posedge sys_clk) disable iff (!n_sys_reset)
    smc_data[31:8] == 24'd0)
    else $error("smc_data lanes above the bus are not zero");

endmodule

bind smc_mac_top smc_mac_assert u_assert (
  .sys_clk (sys_clk), .n_sys_reset (n_sys_reset), .valid_access (valid_access),
  .xfer_size (xfer_size), .mem_rsp (mem_rsp), .mac_done (mac_done),
  .smc_data (smc_data)
);

//--- bench/smc_mac_checker.sv
//----------------------------------------
// checker for the multiple access block
// models the access count, compares mac_done,
// write lanes and final read word
//----------------------------------------

`timescale 1ns/10ps

module smc_mac_checker #(
  parameter smc_mac_pkg::size_t ext_bus_size = smc_mac_pkg::XSIZ_8
) (
  input  logic                  sys_clk,
  input  logic                  n_sys_reset,
  input  logic                  valid_access,
  input  smc_mac_pkg::size_t    xfer_size,
  input  smc_mac_pkg::mem_rsp_t mem_rsp,
  input  logic                  mac_done,
  input  logic [31:0]           read_data,
  input  logic [31:0]           smc_data,
  input  logic [127:0]          test_name,   // ascii, right aligned
  input  logic                  test_read,
  input  smc_mac_pkg::size_t    test_size,
  input  logic [31:0]           test_value,
  output int                    error_count,
  output int                    check_count
);

  function automatic int byte_count(input smc_mac_pkg::size_t size);
    case (size)
      smc_mac_pkg::XSIZ_8:  return 1;
      smc_mac_pkg::XSIZ_16: return 2;
      default:              return 4;
    endcase
  endfunction

  function automatic logic [31:0] low_mask(input int nbytes);
    return (nbytes >= 4) ? 32'hffff_ffff : (32'h1 << (8 * nbytes)) - 32'h1;
  endfunction

  function automatic logic [31:0] replicate(input logic [31:0] v,
                                            input smc_mac_pkg::size_t size);
    case (size)
      smc_mac_pkg::XSIZ_8:  return {4{v[7:0]}};
      smc_mac_pkg::XSIZ_16: return {2{v[15:0]}};
      default:              return v;
    endcase
  endfunction

  localparam int BUS_BYTES = byte_count(ext_bus_size);

  int          exp_left;  // accesses after the current one
  logic [31:0] xfer_val;  // test value cut to the transfer size

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("Fail %0s %0s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  // sampled on rising edges, inputs move on falling edges
  always @(posedge sys_clk or negedge n_sys_reset)
  begin
    if (!n_sys_reset)
    begin
      exp_left    = 0;
      error_count = 0;
      check_count = 0;
    end
    else
    begin
      xfer_val = test_value & low_mask(byte_count(test_size));
      compare("mac_done", {31'd0, exp_left == 0}, {31'd0, mac_done});
      if (mem_rsp.done && !test_read)
        compare("smc_data", (xfer_val >> (exp_left * 8 * BUS_BYTES)) & low_mask(BUS_BYTES),
                smc_data);  // slice k on the low lanes
      if (mem_rsp.done && mem_rsp.latch && exp_left == 0)
        compare("read_data", replicate(xfer_val, test_size), read_data);
      if (valid_access)
        exp_left = (byte_count(xfer_size) > BUS_BYTES) ?
                   byte_count(xfer_size) / BUS_BYTES - 1 : 0;
      else if (mem_rsp.done && exp_left != 0)
        exp_left--;
    end
  end

endmodule

//--- bench/smc_mac_tb.sv
//----------------------------------------
// testbench top for the multiple access block
// clock, reset, tests file reader
// transfer driver and run timeout
//----------------------------------------

`timescale 1ns/10ps

module smc_mac_tb;

  localparam smc_mac_pkg::size_t BUS_SIZE = smc_mac_pkg::XSIZ_8;
  localparam int BUS_BYTES = (BUS_SIZE == smc_mac_pkg::XSIZ_8)  ? 1 :
                             (BUS_SIZE == smc_mac_pkg::XSIZ_16) ? 2 : 4;
  localparam logic [31:0] BUS_MASK = (BUS_BYTES == 4) ? 32'hffff_ffff :
                                     (32'h1 << (8 * BUS_BYTES)) - 32'h1;
  localparam int MAX_GAP = 3;  // idle cycles before an access, at most

  logic                  sys_clk = 1'b0;
  logic                  n_sys_reset;
  logic                  valid_access;
  smc_mac_pkg::size_t    xfer_size;
  smc_mac_pkg::mem_rsp_t mem_rsp;
  logic [31:0]           write_data;
  logic                  mac_done;
  logic [31:0]           read_data;
  logic [31:0]           smc_data;
  logic [127:0]          cur_name;   // test record handed to the checker
  logic                  cur_read;
  smc_mac_pkg::size_t    cur_size;
  logic [31:0]           cur_value;
  int                    error_count;
  int                    check_count;
  int                    cycle_count = 0;
  int                    timeout_limit = 1000;  // replaced once the tests are read

  logic [127:0]          t_name [$];
  logic                  t_read [$];
  smc_mac_pkg::size_t    t_size [$];
  int                    t_bytes [$];
  logic [31:0]           t_value [$];

  always #4 sys_clk = ~sys_clk;  // 8 ns period

  smc_mac_top #(.ext_bus_size(BUS_SIZE)) DUT (
    .sys_clk (sys_clk), .n_sys_reset (n_sys_reset), .valid_access (valid_access),
    .xfer_size (xfer_size), .mem_rsp (mem_rsp), .write_data (write_data),
    .mac_done (mac_done), .read_data (read_data), .smc_data (smc_data)
  );

  smc_mac_checker #(.ext_bus_size(BUS_SIZE)) u_checker (
    .sys_clk (sys_clk), .n_sys_reset (n_sys_reset), .valid_access (valid_access),
    .xfer_size (xfer_size), .mem_rsp (mem_rsp), .mac_done (mac_done),
    .read_data (read_data), .smc_data (smc_data), .test_name (cur_name),
    .test_read (cur_read), .test_size (cur_size), .test_value (cur_value),
    .error_count (error_count), .check_count (check_count)
  );

  // one record per line, lines starting with # skipped
  task automatic load_tests();
    int           fd;
    int           bits;
    string        line;
    logic [127:0] name;
    logic [7:0]   op;
    logic [31:0]  value;
    fd = $fopen("bench/smc_mac_tests.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#" &&
            $sscanf(line, "%s %s %d %h", name, op, bits, value) == 4)
        begin
          t_name.push_back(name);
          t_read.push_back(op == "R");
          t_bytes.push_back(bits / 8);
          t_value.push_back(value);
          case (bits)
            8:       t_size.push_back(smc_mac_pkg::XSIZ_8);
            16:      t_size.push_back(smc_mac_pkg::XSIZ_16);
            default: t_size.push_back(smc_mac_pkg::XSIZ_32);
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // strobe, then each access from the highest slice down
  task automatic run_transfer(input int idx);
    int          n_acc;
    int          k;
    logic [31:0] slice;
    n_acc = (t_bytes[idx] > BUS_BYTES) ? t_bytes[idx] / BUS_BYTES : 1;
    @(negedge sys_clk);
    cur_name     = t_name[idx];
    cur_read     = t_read[idx];
    cur_size     = t_size[idx];
    cur_value    = t_value[idx];
    valid_access = 1'b1;
    xfer_size    = t_size[idx];
    write_data   = t_value[idx];  // held until the next transfer
    @(negedge sys_clk);
    valid_access = 1'b0;
    for (k = n_acc - 1; k >= 0; k--)
    begin
      repeat ($urandom_range(MAX_GAP, 0)) @(negedge sys_clk);
      slice         = (t_value[idx] >> (k * 8 * BUS_BYTES)) & BUS_MASK;
      mem_rsp.data  = ($urandom & ~BUS_MASK) | slice;  // noise above the bus
      mem_rsp.done  = 1'b1;
      mem_rsp.latch = t_read[idx];
      @(negedge sys_clk);
      mem_rsp.done  = 1'b0;
      mem_rsp.latch = 1'b0;
    end
  endtask

  always @(posedge sys_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit)
    begin
      $display("timeout: transfers did not complete");
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial
  begin
    int i;
    void'($urandom(32'h57af));
    n_sys_reset  = 1'b0;
    valid_access = 1'b0;
    xfer_size    = smc_mac_pkg::XSIZ_8;
    write_data   = '0;
    mem_rsp      = '0;
    cur_name     = "reset";
    cur_read     = 1'b0;
    cur_size     = smc_mac_pkg::XSIZ_8;
    cur_value    = '0;
    load_tests();
    if (t_value.size() == 0)
    begin
      $display("error: no tests could be read from bench/smc_mac_tests.txt");
      $display("SIMULATION FAILED");
      $finish;
    end
    else
    begin
      timeout_limit = t_value.size() * 20 + 50;
      repeat (8) @(posedge sys_clk);
      @(negedge sys_clk) n_sys_reset = 1'b1;
      for (i = 0; i < t_value.size(); i++)
      begin
        repeat ($urandom_range(MAX_GAP, 0)) @(negedge sys_clk);  // gap between transfers
        run_transfer(i);
      end
      repeat (3) @(negedge sys_clk);  // idle mac_done checks
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
        $display("SIMULATION PASSED");
      else
        $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

//--- bench/smc_mac_tests.txt
# columns: name  op (R read, W write)  transfer size in bits (8/16/32)
# value in hex, right aligned in the transfer bytes
wr_byte_a5     W 8  a5
rd_byte_3c     R 8  3c
wr_half_1234   W 16 1234
rd_half_beef   R 16 beef
wr_word_cafe   W 32 cafef00d
rd_word_0123   R 32 01234567
rd_byte_ff     R 8  ff
rd_word_8000   R 32 80000001
wr_half_00ff   W 16 00ff
rd_half_5aa5   R 16 5aa5
wr_byte_00     W 8  00
rd_word_dead   R 32 deadbeef
wr_word_ffff   W 32 ffffffff
rd_half_0001   R 16 0001
rd_byte_81     R 8  81
wr_word_a5c3   W 32 a5c3e10f
rd_word_0000   R 32 00000000

//--- flist.f
hw/smc_mac_pkg.sv
hw/smc_access_counter.sv
hw/smc_read_assemble.sv
hw/smc_write_lanes.sv
hw/smc_mac_top.sv
bench/smc_mac_assert.sv
bench/smc_mac_checker.sv
bench/smc_mac_tb.sv

//--- hw/smc_access_counter.sv
//----------------------------------------
// access counter for multiple accesses
// stores transfer size, counts accesses down
// flags the last access with mac_done
//----------------------------------------

`timescale 1ns/10ps

module smc_access_counter #(
  parameter smc_mac_pkg::size_t ext_bus_size = smc_mac_pkg::XSIZ_8  // external bus width
) (
  input  logic                    sys_clk,
  input  logic                    n_sys_reset,   // async, active low
  input  logic                    valid_access,  // one cycle start strobe
  input  smc_mac_pkg::size_t      xfer_size,     // valid with the strobe
  input  logic                    access_done,   // end of one external access
  output smc_mac_pkg::acc_state_t acc_state,     // stored size and remaining count
  output logic                    mac_done       // last access of the transfer
);

  logic [1:0] load_count;  // count for a new transfer
  logic       count_zero;  // no accesses left after this one
  logic       count_dec;   // step to the next access

  //----------------------------------------
  // access count decode
  //----------------------------------------

  // bus size is fixed, so only the transfer size matters here
  always_comb
  begin
    load_count = smc_mac_pkg::accesses_for(xfer_size, ext_bus_size);
  end

  assign count_zero = (acc_state.count == 2'd0);
  assign count_dec  = access_done && !count_zero;  // hold at zero once done

  //----------------------------------------
  // stored transfer size
  //----------------------------------------

  always_ff @(posedge sys_clk or negedge n_sys_reset)
  begin
    if (!n_sys_reset)
    begin
      acc_state.xfer_size <= smc_mac_pkg::XSIZ_8;
    end
    else if (valid_access)
    begin
      acc_state.xfer_size <= xfer_size;  // kept for the whole transfer
    end
  end

  //----------------------------------------
  // remaining access count
  //----------------------------------------

  // a new strobe never lands on a done, but the load wins anyway
  always_ff @(posedge sys_clk or negedge n_sys_reset)
  begin
    if (!n_sys_reset)
    begin
      acc_state.count <= 2'd0;
    end
    else if (valid_access)
    begin
      acc_state.count <= load_count;  // visible the cycle after the strobe
    end
    else if (count_dec)
    begin
      acc_state.count <= acc_state.count - 2'd1;
    end
  end

  // high during the last access and while idle
  assign mac_done = count_zero;

endmodule

//--- hw/smc_mac_pkg.sv
//----------------------------------------
// shared types for the multiple access block
// size encodings, access state, bus response
// helpers for byte and access counts
//----------------------------------------

package smc_mac_pkg;

  localparam int DATA_W = 32;  // internal data path width

  // transfer and bus size, log2 of the byte count
  typedef enum logic [1:0] {
    XSIZ_8  = 2'h0,
    XSIZ_16 = 2'h1,
    XSIZ_32 = 2'h2
  } size_t;

  // state shared by the counter and both data blocks
  typedef struct packed {
    size_t      xfer_size;  // size stored at valid_access
    logic [1:0] count;      // accesses still to come after this one
  } acc_state_t;

  // external memory side of one access
  typedef struct packed {
    logic              done;   // last cycle of an access
    logic              latch;  // read data valid
    logic [DATA_W-1:0] data;   // bus data, low lanes used
  } mem_rsp_t;

  //----------------------------------------
  // helpers
  //----------------------------------------

  function automatic logic [2:0] size_bytes(input size_t size);
    case (size)
      XSIZ_8:  return 3'd1;
      XSIZ_16: return 3'd2;
      default: return 3'd4;  // 32 bit and the unused code
    endcase
  endfunction

  // accesses minus one, transfer bytes over bus bytes
  function automatic logic [1:0] accesses_for(input size_t xfer, input size_t bus);
    logic [1:0] ratio_log2;
    if (xfer <= bus)
      return 2'd0;  // fits in one access
    ratio_log2 = xfer - bus;  // sizes are log2 so the ratio is a shift
    return 2'((3'd1 << ratio_log2) - 3'd1);
  endfunction

endpackage

//--- hw/smc_mac_top.sv
//----------------------------------------
// multiple access controller top level
// counter, read assembly and write lanes
//----------------------------------------

`timescale 1ns/10ps

module smc_mac_top #(
  parameter smc_mac_pkg::size_t ext_bus_size = smc_mac_pkg::XSIZ_8  // external bus width
) (
  input  logic                           sys_clk,
  input  logic                           n_sys_reset,   // async, active low
  input  logic                           valid_access,  // start of a transfer
  input  smc_mac_pkg::size_t             xfer_size,     // valid with the strobe
  input  smc_mac_pkg::mem_rsp_t          mem_rsp,       // external bus response
  input  logic [smc_mac_pkg::DATA_W-1:0] write_data,    // internal write word
  output logic                           mac_done,      // last access flag
  output logic [smc_mac_pkg::DATA_W-1:0] read_data,     // internal read word
  output logic [smc_mac_pkg::DATA_W-1:0] smc_data       // external write lanes
);

  smc_mac_pkg::acc_state_t acc_state;  // size and remaining count

  //----------------------------------------
  // access counting
  //----------------------------------------

  smc_access_counter #(
    .ext_bus_size (ext_bus_size)
  ) u_counter (
    .sys_clk      (sys_clk),
    .n_sys_reset  (n_sys_reset),
    .valid_access (valid_access),
    .xfer_size    (xfer_size),
    .access_done  (mem_rsp.done),  // every bus access end steps the count
    .acc_state    (acc_state),
    .mac_done     (mac_done)
  );

  //----------------------------------------
  // data paths
  //----------------------------------------

  smc_read_assemble #(
    .ext_bus_size (ext_bus_size)
  ) u_read (
    .sys_clk     (sys_clk),
    .n_sys_reset (n_sys_reset),
    .acc_state   (acc_state),
    .mem_rsp     (mem_rsp),
    .read_data   (read_data)
  );

  smc_write_lanes #(
    .ext_bus_size (ext_bus_size)
  ) u_write (
    .acc_state  (acc_state),
    .write_data (write_data),
    .smc_data   (smc_data)
  );

endmodule

//--- hw/smc_read_assemble.sv
//----------------------------------------
// read assembly for multiple accesses
// holding register filled slot by slot
// final word replicated to 32 bits
//----------------------------------------

`timescale 1ns/10ps

module smc_read_assemble #(
  parameter smc_mac_pkg::size_t ext_bus_size = smc_mac_pkg::XSIZ_8  // external bus width
) (
  input  logic                                sys_clk,
  input  logic                                n_sys_reset,  // async, active low
  input  smc_mac_pkg::acc_state_t             acc_state,    // from the counter
  input  smc_mac_pkg::mem_rsp_t               mem_rsp,      // external bus response
  output logic [smc_mac_pkg::DATA_W-1:0]      read_data     // word to the internal bus
);

  localparam int W         = smc_mac_pkg::DATA_W;
  localparam int BUS_BYTES = int'(smc_mac_pkg::size_bytes(ext_bus_size));
  localparam int BUS_W     = 8 * BUS_BYTES;  // bits per access

  logic [W-1:0] r_hold;      // bytes of earlier accesses
  logic [W-1:0] bus_lanes;   // live bus bytes, zero above bus width
  logic [W-1:0] slot_ones;   // ones over one bus width
  logic [W-1:0] hold_next;   // holding register with this access merged
  logic [W-1:0] word_sel;    // word before replication
  int unsigned  slot_lsb;    // bit offset of the current slot
  logic         last_latch;  // final read access in progress

  //----------------------------------------
  // slot merge
  //----------------------------------------

  always_comb
  begin
    bus_lanes              = '0;
    bus_lanes[BUS_W-1:0]   = mem_rsp.data[BUS_W-1:0];  // upper lanes are noise
    slot_ones              = '0;
    slot_ones[BUS_W-1:0]   = '1;
    slot_lsb               = acc_state.count * BUS_W;  // count x bus bytes, in bits
    // replace the current slot, keep every other byte
    hold_next = (r_hold & ~(slot_ones << slot_lsb)) | (bus_lanes << slot_lsb);
  end

  //----------------------------------------
  // holding register
  //----------------------------------------

  always_ff @(posedge sys_clk or negedge n_sys_reset)
  begin
    if (!n_sys_reset)
    begin
      r_hold <= '0;
    end
    else if (mem_rsp.latch)
    begin
      r_hold <= hold_next;  // one edge after each latched access
    end
  end

  //----------------------------------------
  // read word and lane replication
  //----------------------------------------

  // lowest slot comes straight from the bus on the last access
  assign last_latch = mem_rsp.latch && (acc_state.count == 2'd0);
  assign word_sel   = last_latch ? hold_next : r_hold;

  always_comb
  begin
    case (acc_state.xfer_size)
      smc_mac_pkg::XSIZ_8:
      begin
        read_data = {4{word_sel[7:0]}};   // byte on every lane
      end
      smc_mac_pkg::XSIZ_16:
      begin
        read_data = {2{word_sel[15:0]}};  // halfword on both halves
      end
      default:
      begin
        read_data = word_sel;             // full word as is
      end
    endcase
  end

endmodule

//--- hw/smc_write_lanes.sv
//----------------------------------------
// write lane steering
// slice of write_data for the current access
// placed on the low external lanes
//----------------------------------------

`timescale 1ns/10ps

module smc_write_lanes #(
  parameter smc_mac_pkg::size_t ext_bus_size = smc_mac_pkg::XSIZ_8  // external bus width
) (
  input  smc_mac_pkg::acc_state_t             acc_state,   // from the counter
  input  logic [smc_mac_pkg::DATA_W-1:0]      write_data,  // held for the transfer
  output logic [smc_mac_pkg::DATA_W-1:0]      smc_data     // to the external bus
);

  localparam int W         = smc_mac_pkg::DATA_W;
  localparam int BUS_BYTES = int'(smc_mac_pkg::size_bytes(ext_bus_size));
  localparam int BUS_W     = 8 * BUS_BYTES;  // bits per access

  logic [W-1:0] slice;       // write_data moved so the current slot is at bit 0
  logic [2:0]   xfer_bytes;  // bytes in the stored transfer
  int unsigned  slot_lsb;    // bit offset of the current slot

  //----------------------------------------
  // slice select
  //----------------------------------------

  always_comb
  begin
    slot_lsb   = acc_state.count * BUS_W;  // highest slot goes out first
    slice      = write_data >> slot_lsb;
    xfer_bytes = smc_mac_pkg::size_bytes(acc_state.xfer_size);
  end

  //----------------------------------------
  // lane fill
  //----------------------------------------

  // a lane carries data only inside the bus and inside the transfer
  always_comb
  begin
    smc_data = '0;  // lanes above the bus stay zero
    for (int b = 0; b < BUS_BYTES; b++)
    begin
      if (b < int'(xfer_bytes))
      begin
        smc_data[8*b +: 8] = slice[8*b +: 8];
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the multiple access testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f --top-module smc_mac_tb -o smc_mac_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/smc_mac_sim)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
